// File: Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := dwc_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/dwc_assert.sv
`timescale 1ns/1ns
`default_nettype none

`include "dwc_settings.svh"

module dwc_assert (
  input wire                   ACLK,
  input wire                   sysReset,
  input wire                   cmd_valid,
  input wire [2:0]             cmd_size,
  input wire                   slv_valid,
  input wire                   slv_ready,
  input wire [`DWC_ID_W-1:0]   slv_id,
  input wire [`DWC_ADDR_W-1:0] slv_addr,
  input wire [7:0]             slv_len,
  input wire [2:0]             slv_size
);

  // Read by the testbench at the end of the run
  int fail_count = 0;

  // Stalled slave command keeps valid and all fields
  slv_stable_a : assert property (@(posedge ACLK) disable iff (!sysReset)
    (slv_valid && !slv_ready) |=> (slv_valid && $stable({slv_id, slv_addr, slv_len, slv_size})))
  else begin
    fail_count++;
    $error("slave command dropped or changed before its transfer");
  end

  // Master never offers more than 8 bytes per beat
  cmd_size_a : assert property (@(posedge ACLK) disable iff (!sysReset)
    cmd_valid |-> (cmd_size <= 3'(`DWC_MST_SIZE_MAX)))
  else begin
    fail_count++;
    $error("cmd_size above the master bus width");
  end

  // Output idle while reset is applied
  rst_idle_a : assert property (@(posedge ACLK) !sysReset |-> !slv_valid)
  else begin
    fail_count++;
    $error("slv_valid high during reset");
  end

endmodule

bind dwc_downconv_top dwc_assert u_assert (
  .ACLK      (ACLK),
  .sysReset  (sysReset),
  .cmd_valid (cmd_valid),
  .cmd_size  (cmd_size),
  .slv_valid (slv_valid),
  .slv_ready (slv_ready),
  .slv_id    (slv_id),
  .slv_addr  (slv_addr),
  .slv_len   (slv_len),
  .slv_size  (slv_size)
);

`default_nettype wire

// File: dv/dwc_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module dwc_clk_gen (
  output logic ACLK,
  output logic sysReset
);

  // 20 ns period
  localparam int HALF_PERIOD = 10;

  initial begin
    ACLK = 1'b0;
    forever #HALF_PERIOD ACLK = ~ACLK;
  end

  // Reset held for three rising edges, released just after the third
  initial begin
    sysReset = 1'b0;
    repeat (3) @(posedge ACLK);
    #2;
    sysReset = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/dwc_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dwc_settings.svh"

module dwc_tb;

  // Tests take a few hundred cycles in total
  localparam int TIMEOUT_CYCLES = 4000;
  // Packed slave command of id, addr, len and size
  localparam int PW = `DWC_ID_W + `DWC_ADDR_W + 11;

  logic                   ACLK;
  logic                   sysReset;
  logic                   cmd_valid;
  logic                   cmd_ready;
  logic [`DWC_ID_W-1:0]   cmd_id;
  logic [`DWC_ADDR_W-1:0] cmd_addr;
  logic [7:0]             cmd_len;
  logic [2:0]             cmd_size;
  logic                   slv_valid;
  logic                   slv_ready;
  logic [`DWC_ID_W-1:0]   slv_id;
  logic [`DWC_ADDR_W-1:0] slv_addr;
  logic [7:0]             slv_len;
  logic [2:0]             slv_size;

  logic [31:0]            lfsr_state;
  logic                   rand_ready;
  logic [PW-1:0]          exp_q[$];
  int                     err_cnt;
  int                     check_cnt;
  int                     tests_failed;
  int                     cycle_cnt = 0;

  dwc_clk_gen clk_gen (.ACLK (ACLK), .sysReset (sysReset));

  dwc_downconv_top UUT (
    .ACLK      (ACLK),
    .sysReset  (sysReset),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_id    (cmd_id),
    .cmd_addr  (cmd_addr),
    .cmd_len   (cmd_len),
    .cmd_size  (cmd_size),
    .slv_valid (slv_valid),
    .slv_ready (slv_ready),
    .slv_id    (slv_id),
    .slv_addr  (slv_addr),
    .slv_len   (slv_len),
    .slv_size  (slv_size)
  );

  ////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////

  // Galois form with taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Expected slave chunks of one accepted command
  task automatic model_cmd(input logic [3:0] id, input logic [31:0] addr,
                           input logic [7:0] len, input logic [2:0] size);
    logic [2:0]  ssize;
    logic [31:0] a;
    int          total;
    int          beats;
    ssize = (size > 3'(`DWC_SLV_SIZE_MAX)) ? 3'(`DWC_SLV_SIZE_MAX) : size;
    // Start of the master beat that holds the first byte
    a     = (addr >> size) << size;
    // Each master beat becomes 2**(size-ssize) slave beats
    total = (int'(len) + 1) << (size - ssize);
    while (total > 0) begin
      beats = (total > 256) ? 256 : total;
      exp_q.push_back({id, a, 8'(beats - 1), ssize});
      a     = a + (32'(beats) << ssize);
      total = total - beats;
    end
  endtask

  ////////////////////////////////////////
  // Drivers and monitor
  ////////////////////////////////////////

  task automatic flag_error(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  // Starts and ends 2 ns after a rising edge
  task automatic send_cmd(input logic [3:0] id, input logic [31:0] addr,
                          input logic [7:0] len, input logic [2:0] size);
    cmd_valid = 1'b1;
    cmd_id    = id;
    cmd_addr  = addr;
    cmd_len   = len;
    cmd_size  = size;
    @(negedge ACLK);
    while (cmd_ready !== 1'b1) begin
      @(negedge ACLK);
    end
    @(posedge ACLK);
    #2;
    model_cmd(id, addr, len, size);
    cmd_valid = 1'b0;
  endtask

  // Output must go idle once all expected chunks are seen
  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge ACLK);
    end
    repeat (3) @(posedge ACLK);
    @(negedge ACLK);
    check_cnt++;
    if (slv_valid !== 1'b0) begin
      $display("Error at %0t ns: slave output still busy after the last expected command", $time);
      err_cnt++;
    end
    @(posedge ACLK);
    #2;
  endtask

  task automatic end_test(input string name, input int err0);
    if (err_cnt == err0) begin
      $display("Test %s: done, no errors", name);
    end else begin
      tests_failed++;
      $display("Test %s: done, %0d errors", name, err_cnt - err0);
    end
  endtask

  // Random slave ready when enabled
  always @(posedge ACLK) begin
    logic [31:0] b;
    if (rand_ready) begin
      #2;
      rand_bits(1, b);
      slv_ready = b[0];
    end
  end

  // Transfer seen at the falling edge before the rising edge that takes it
  always @(negedge ACLK) begin
    logic [PW-1:0] got;
    logic [PW-1:0] exp_cmd;
    if (sysReset && slv_valid && slv_ready) begin
      got = {slv_id, slv_addr, slv_len, slv_size};
      check_cnt++;
      if (exp_q.size() == 0) begin
        $display("Error at %0t ns: slave command addr %08h arrived with none expected",
                 $time, slv_addr);
        err_cnt++;
      end else begin
        exp_cmd = exp_q.pop_front();
        if (got !== exp_cmd) begin
          flag_error($sformatf("slave id/addr/len/size %0h/%08h/%0d/%0d, expected %0h/%08h/%0d/%0d",
                     slv_id, slv_addr, slv_len, slv_size, exp_cmd[46:43], exp_cmd[42:11],
                     exp_cmd[10:3], exp_cmd[2:0]));
        end
      end
    end
  end

  always @(posedge ACLK) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic check_reset_state();
    int err0;
    int n;
    err0 = err_cnt;
    @(negedge ACLK);
    check_cnt += 2;
    if (cmd_ready !== 1'b1) begin
      flag_error("cmd_ready not high after reset");
    end
    if (slv_valid !== 1'b0) begin
      flag_error("slv_valid not low after reset");
    end
    @(posedge ACLK);
    #2;
    slv_ready = 1'b1;
    send_cmd(4'h5, 32'h0000_1237, 8'd9, 3'd2);
    // Accept edge counts as the first of three
    n = 0;
    do begin
      @(negedge ACLK);
      n++;
    end while (!slv_valid && n < 10);
    check_cnt++;
    if (n != 3) flag_error($sformatf("slv_valid after %0d edges, expected 3", n));
    @(posedge ACLK);
    #2;
    wait_drain();
    end_test("reset", err0);
  endtask

  task automatic widen_size3();
    int          err0;
    logic [31:0] r_len;
    logic [31:0] r_addr;
    logic [31:0] r_id;
    err0 = err_cnt;
    for (int i = 0; i < 6; i++) begin
      rand_bits(7, r_len);
      rand_bits(32, r_addr);
      rand_bits(4, r_id);
      send_cmd(r_id[3:0], r_addr, {1'b0, r_len[6:0]}, 3'd3);
    end
    wait_drain();
    end_test("widening", err0);
  endtask

  task automatic split_long_bursts();
    int err0;
    err0 = err_cnt;
    // 512 beats, two full chunks 1024 bytes apart
    send_cmd(4'h3, 32'h0000_2004, 8'd255, 3'd3);
    // 400 beats, 256 then 144
    send_cmd(4'h9, 32'h0001_0013, 8'd199, 3'd3);
    wait_drain();
    end_test("chunking", err0);
  endtask

  task automatic random_backpressure();
    int          err0;
    logic [31:0] r;
    logic [3:0]  ids [8];
    logic [31:0] addrs [8];
    logic [7:0]  lens [8];
    logic [2:0]  sizes [8];
    err0 = err_cnt;
    // Stream drawn before ready starts stepping the LFSR
    for (int i = 0; i < 8; i++) begin
      rand_bits(4, r);
      ids[i] = r[3:0];
      rand_bits(32, r);
      addrs[i] = r;
      rand_bits(8, r);
      lens[i] = r[7:0];
      rand_bits(2, r);
      sizes[i] = {1'b0, r[1:0]};
    end
    rand_ready = 1'b1;
    for (int i = 0; i < 8; i++) begin
      send_cmd(ids[i], addrs[i], lens[i], sizes[i]);
    end
    wait_drain();
    rand_ready = 1'b0;
    @(posedge ACLK);
    #2;
    slv_ready = 1'b1;
    end_test("backpressure", err0);
  endtask

  task automatic fill_pipeline();
    int          err0;
    int          accepted;
    int          tries;
    logic        stalled;
    logic [31:0] r;
    err0      = err_cnt;
    accepted  = 0;
    tries     = 0;
    stalled   = 1'b0;
    slv_ready = 1'b0;
    while (!stalled && tries < 12) begin
      rand_bits(32, r);
      cmd_valid = 1'b1;
      cmd_id    = 4'(tries);
      cmd_addr  = r;
      cmd_len   = 8'(tries * 3);
      cmd_size  = 3'(tries % 4);
      @(negedge ACLK);
      if (cmd_ready === 1'b1) begin
        @(posedge ACLK);
        #2;
        model_cmd(cmd_id, cmd_addr, cmd_len, cmd_size);
        accepted++;
      end else begin
        stalled = 1'b1;
      end
      tries++;
    end
    // FIFO entries plus holding register plus splitter
    check_cnt++;
    if (accepted != `DWC_CMD_FIFO_DEPTH + 2) begin
      flag_error($sformatf("%0d commands accepted before cmd_ready fell, expected %0d",
                 accepted, `DWC_CMD_FIFO_DEPTH + 2));
    end
    repeat (4) begin
      @(negedge ACLK);
      check_cnt++;
      if (cmd_ready !== 1'b0) begin
        flag_error("cmd_ready rose while the slave was stalled");
      end
    end
    @(posedge ACLK);
    #2;
    cmd_valid = 1'b0;
    slv_ready = 1'b1;
    wait_drain();
    end_test("fill", err0);
  endtask

  initial begin
    int total_err;
    lfsr_state   = 32'h36040bde;
    cmd_valid    = 1'b0;
    cmd_id       = '0;
    cmd_addr     = '0;
    cmd_len      = '0;
    cmd_size     = '0;
    slv_ready    = 1'b0;
    rand_ready   = 1'b0;
    err_cnt      = 0;
    check_cnt    = 0;
    tests_failed = 0;
    wait (sysReset === 1'b1);
    @(posedge ACLK);
    #2;
    check_reset_state();
    widen_size3();
    split_long_bursts();
    random_backpressure();
    fill_pipeline();
    total_err = err_cnt + UUT.u_assert.fail_count;
    $display("Summary: 5 tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_failed, check_cnt, err_cnt, UUT.u_assert.fail_count);
    if (total_err == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/dwc_burst_splitter.sv
`timescale 1ns/1ns
`default_nettype none

`include "dwc_settings.svh"

module dwc_burst_splitter (
  input  wire                    ACLK,
  input  wire                    sysReset,
  dwc_hold_if.dst                hold,
  output logic                   slv_valid,
  input  wire                    slv_ready,
  output logic [`DWC_ID_W-1:0]   slv_id,
  output logic [`DWC_ADDR_W-1:0] slv_addr,
  output logic [7:0]             slv_len,
  output logic [2:0]             slv_size
);

  localparam int AW = `DWC_ADDR_W;
  // Beat counts, one bit above the minus-one width
  localparam int CW = `DWC_TOTAL_W + 1;

  logic [CW-1:0] beats_left;
  logic [CW-1:0] src_beats;
  logic [CW-1:0] nxt_left;
  logic [7:0]    nxt_len;
  logic [AW-1:0] nxt_addr;
  logic          xfer;
  logic          last_chunk;

  // Chunk length minus one, capped at 256 beats
  function automatic logic [7:0] chunk_m1(input logic [CW-1:0] beats);
    logic [7:0] res;
    if (beats > CW'(256)) begin
      res = 8'hFF;
    end else begin
      res = 8'(beats - CW'(1));
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Chunk control
  ////////////////////////////////////////

  assign xfer       = slv_valid && slv_ready;
  // No beats left behind the chunk on the bus
  assign last_chunk = (beats_left == '0);

  // Take only when idle or the last chunk leaves now
  assign hold.take = hold.hold_valid && (!slv_valid || (xfer && last_chunk));

  always_comb begin
    // New entry or the rest of the current one
    if (hold.take) begin
      src_beats = CW'(hold.dec.total_m1) + CW'(1);
    end else begin
      src_beats = beats_left;
    end
    nxt_len  = chunk_m1(src_beats);
    nxt_left = src_beats - (CW'(nxt_len) + CW'(1));
    // Step past the chunk just sent
    nxt_addr = slv_addr + ((AW'(slv_len) + AW'(1)) << slv_size);
  end

  always_ff @(posedge ACLK or negedge sysReset) begin
    if (!sysReset) begin
      slv_valid  <= 1'b0;
      beats_left <= '0;
    end else if (hold.take) begin
      slv_valid  <= 1'b1;
      beats_left <= nxt_left;
    end else if (xfer && !last_chunk) begin
      beats_left <= nxt_left;
    end else if (xfer) begin
      // Last chunk gone and nothing waiting
      slv_valid  <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Slave command fields
  ////////////////////////////////////////

  // Held stable until the transfer
  always_ff @(posedge ACLK) begin
    if (hold.take) begin
      slv_id   <= hold.cmd.id;
      slv_addr <= hold.dec.aligned_addr;
      slv_len  <= nxt_len;
      slv_size <= hold.dec.slv_size;
    end else if (xfer && !last_chunk) begin
      slv_addr <= nxt_addr;
      slv_len  <= nxt_len;
    end
  end

endmodule

`default_nettype wire

// File: rtl/dwc_cmd_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module dwc_cmd_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  wire      ACLK,
  input  wire      sysReset,
  input  wire      wr_en,
  input  payload_t wr_data,
  output logic     full,
  input  wire      rd_en,
  output payload_t rd_data,
  output logic     empty
);

  // Pointer and occupancy widths
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            do_push;
  logic            do_pop;

  // Pop frees a slot, so a full FIFO still takes a push
  assign do_pop  = rd_en && !empty;
  assign do_push = wr_en && (!full || do_pop);

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  // Head entry shown without a register stage
  assign rd_data = mem[rd_ptr];

  // Storage array
  always_ff @(posedge ACLK) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers and count
  always_ff @(posedge ACLK or negedge sysReset) begin
    if (!sysReset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        // Wrap for any depth, not only powers of two
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/dwc_downconv_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dwc_settings.svh"

module dwc_downconv_top (
  input  wire                    ACLK,
  input  wire                    sysReset,
  // Master side command
  input  wire                    cmd_valid,
  output logic                   cmd_ready,
  input  wire  [`DWC_ID_W-1:0]   cmd_id,
  input  wire  [`DWC_ADDR_W-1:0] cmd_addr,
  input  wire  [7:0]             cmd_len,
  input  wire  [2:0]             cmd_size,
  // Slave side command
  output logic                   slv_valid,
  input  wire                    slv_ready,
  output logic [`DWC_ID_W-1:0]   slv_id,
  output logic [`DWC_ADDR_W-1:0] slv_addr,
  output logic [7:0]             slv_len,
  output logic [2:0]             slv_size
);

  dwc_pkg::wr_cmd_t in_cmd;
  dwc_pkg::wr_cmd_t head_data;
  logic             fifo_full;
  logic             fifo_empty;
  logic             fifo_rd_en;

  // Pack the command fields
  assign in_cmd.id   = cmd_id;
  assign in_cmd.addr = cmd_addr;
  assign in_cmd.len  = cmd_len;
  assign in_cmd.size = cmd_size;

  assign cmd_ready = !fifo_full;

  // Input stage
  dwc_cmd_fifo #(
    .payload_t (dwc_pkg::wr_cmd_t),
    .DEPTH     (`DWC_CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .ACLK     (ACLK),
    .sysReset (sysReset),
    .wr_en    (cmd_valid && cmd_ready),
    .wr_data  (in_cmd),
    .full     (fifo_full),
    .rd_en    (fifo_rd_en),
    .rd_data  (head_data),
    .empty    (fifo_empty)
  );

  dwc_hold_if hold_bus ();

  // Holding register with decode
  dwc_hold_reg u_hold_reg (
    .ACLK       (ACLK),
    .sysReset   (sysReset),
    .head_data  (head_data),
    .fifo_empty (fifo_empty),
    .fifo_rd_en (fifo_rd_en),
    .hold       (hold_bus.src)
  );

  // Splitter and output stage
  dwc_burst_splitter u_splitter (
    .ACLK      (ACLK),
    .sysReset  (sysReset),
    .hold      (hold_bus.dst),
    .slv_valid (slv_valid),
    .slv_ready (slv_ready),
    .slv_id    (slv_id),
    .slv_addr  (slv_addr),
    .slv_len   (slv_len),
    .slv_size  (slv_size)
  );

endmodule

`default_nettype wire

// File: rtl/dwc_hold_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dwc_hold_if;

  // Entry present in the holding register
  logic               hold_valid;
  // Raw command as popped from the FIFO
  dwc_pkg::wr_cmd_t   cmd;
  // Registered decode of that command
  dwc_pkg::wr_dec_t   dec;
  // Splitter consumes the entry this cycle
  logic               take;

  // Holding register side
  modport src (output hold_valid, output cmd, output dec, input take);

  // Splitter side
  modport dst (input hold_valid, input cmd, input dec, output take);

endinterface

`default_nettype wire

// File: rtl/dwc_hold_reg.sv
`timescale 1ns/1ns
`default_nettype none

`include "dwc_settings.svh"

module dwc_hold_reg (
  input  wire              ACLK,
  input  wire              sysReset,
  input  dwc_pkg::wr_cmd_t head_data,
  input  wire              fifo_empty,
  output logic             fifo_rd_en,
  dwc_hold_if.src          hold
);

  localparam int AW = `DWC_ADDR_W;
  localparam int TW = `DWC_TOTAL_W;

  logic             pass_data;
  logic             valid_q;
  dwc_pkg::wr_dec_t dec_next;

  ////////////////////////////////////////
  // Hold control
  ////////////////////////////////////////

  // Load when FIFO has data and the slot is free or leaving now
  assign pass_data  = !fifo_empty && (!valid_q || hold.take);

  // Loading the register pops the FIFO head
  assign fifo_rd_en = pass_data;

  always_ff @(posedge ACLK or negedge sysReset) begin
    if (!sysReset) begin
      valid_q <= 1'b0;
    end else if (pass_data) begin
      valid_q <= 1'b1;
    end else if (hold.take) begin
      valid_q <= 1'b0;
    end
  end

  assign hold.hold_valid = valid_q;

  ////////////////////////////////////////
  // Pre-decode of the FIFO head
  ////////////////////////////////////////

  always_comb begin
    // Narrow sizes pass, wider ones clamp to the slave bus
    if (head_data.size > 3'(`DWC_SLV_SIZE_MAX)) begin
      dec_next.slv_size = 3'(`DWC_SLV_SIZE_MAX);
    end else begin
      dec_next.slv_size = head_data.size;
    end

    // Slave beats per master beat
    dec_next.ratio_shift = 2'(head_data.size - dec_next.slv_size);

    // Drop low address bits below the master size
    dec_next.aligned_addr = head_data.addr & ~((AW'(1) << head_data.size) - AW'(1));

    // Master beats scaled by the ratio, kept as count minus one
    dec_next.total_m1 = ((TW'(head_data.len) + TW'(1)) << dec_next.ratio_shift) - TW'(1);
  end

  ////////////////////////////////////////
  // Payload registers
  ////////////////////////////////////////

  // Splitter sees only flopped values
  always_ff @(posedge ACLK) begin
    if (pass_data) begin
      hold.cmd <= head_data;
      hold.dec <= dec_next;
    end
  end

endmodule

`default_nettype wire

// File: rtl/dwc_pkg.sv
`default_nettype none

`include "dwc_settings.svh"

package dwc_pkg;

  ////////////////////////////////////////
  // Master side write command
  ////////////////////////////////////////

  typedef struct packed {
    // Transaction id
    logic [`DWC_ID_W-1:0]   id;
    // Start byte address, may be unaligned
    logic [`DWC_ADDR_W-1:0] addr;
    // Beats minus one
    logic [7:0]             len;
    // Bytes per beat as a power of two
    logic [2:0]             size;
  } wr_cmd_t;

  ////////////////////////////////////////
  // Values decoded in the holding register
  ////////////////////////////////////////

  typedef struct packed {
    // Address aligned down to the master size
    logic [`DWC_ADDR_W-1:0] aligned_addr;
    // Size clamped to the slave width
    logic [2:0]             slv_size;
    // Slave beats over the whole command, minus one
    logic [`DWC_TOTAL_W-1:0] total_m1;
    // Slave beats per master beat as a power of two
    logic [1:0]             ratio_shift;
  } wr_dec_t;

endpackage

`default_nettype wire

// File: rtl/dwc_settings.svh
`ifndef DWC_SETTINGS_SVH
`define DWC_SETTINGS_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

// Byte address on both sides
`define DWC_ADDR_W 32

// Transaction id, passed through untouched
`define DWC_ID_W 4

////////////////////////////////////////
// Converter sizing
////////////////////////////////////////

// Command FIFO entries
`define DWC_CMD_FIFO_DEPTH 4

// Size codes, 2 is 4 bytes and 3 is 8 bytes
`define DWC_SLV_SIZE_MAX 2
`define DWC_MST_SIZE_MAX 3

// Total slave beats minus one
`define DWC_TOTAL_W 11

`endif

// File: src.f
+incdir+rtl
rtl/dwc_pkg.sv
rtl/dwc_hold_if.sv
rtl/dwc_cmd_fifo.sv
rtl/dwc_hold_reg.sv
rtl/dwc_burst_splitter.sv
rtl/dwc_downconv_top.sv
dv/dwc_clk_gen.sv
dv/dwc_assert.sv
dv/dwc_tb.sv
